/* common/scratch_pkg.sv */
package scratch_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Geometry

    localparam int NUM_REQS      = 4;
    localparam int NUM_BANKS     = 4;
    localparam int ROWS_PER_BANK = 16;
    localparam int WORD_BYTES    = 4;

    localparam int BANK_SEL_BITS = $clog2(NUM_BANKS);
    localparam int ROW_BITS      = $clog2(ROWS_PER_BANK);
    localparam int REQ_SEL_BITS  = $clog2(NUM_REQS);

    // Word address is row above bank select
    localparam int ADDR_BITS     = ROW_BITS + BANK_SEL_BITS;
    localparam int WORD_BITS     = WORD_BYTES * 8;

    localparam int TAG_BITS      = 4;
    localparam int CTR_BITS      = 16;

    ////////////////////////////////////////////////////////////////////////////
    // Shared types

    typedef logic [WORD_BITS-1:0]     word_t;
    typedef logic [WORD_BYTES-1:0]    byteen_t;
    typedef logic [TAG_BITS-1:0]      tag_t;
    typedef logic [BANK_SEL_BITS-1:0] bank_id_t;
    typedef logic [ROW_BITS-1:0]      row_t;
    typedef logic [REQ_SEL_BITS-1:0]  req_idx_t;
    typedef logic [CTR_BITS-1:0]      ctr_t;

endpackage

/* src/bank_arbiter.sv */
module bank_arbiter (
    input  logic                                              clk,
    input  logic                                              reset,
    input  logic [scratch_pkg::NUM_REQS-1:0]                  req_valid,
    input  scratch_pkg::bank_id_t [scratch_pkg::NUM_REQS-1:0] req_bank,
    output logic [scratch_pkg::NUM_REQS-1:0]                  req_ready,
    output logic [scratch_pkg::NUM_BANKS-1:0]                 bank_valid,
    output scratch_pkg::req_idx_t [scratch_pkg::NUM_BANKS-1:0] bank_winner
);

    // Fixed priority per bank, lowest index wins
    always_comb begin
        bank_valid  = '0;
        bank_winner = '0;
        req_ready   = '0;
        for (int b = 0; b < scratch_pkg::NUM_BANKS; b++) begin
            // Walk downwards so the last hit is the lowest requester
            for (int i = scratch_pkg::NUM_REQS - 1; i >= 0; i--) begin
                if (req_valid[i] && (req_bank[i] == scratch_pkg::bank_id_t'(b))) begin
                    bank_valid[b]  = 1'b1;
                    bank_winner[b] = scratch_pkg::req_idx_t'(i);
                end
            end
            if (bank_valid[b]) begin
                req_ready[bank_winner[b]] = 1'b1;
            end
        end
    end

    // A grant never goes to an idle requester
    assert property (@(posedge clk) disable iff (reset)
        (req_ready & ~req_valid) == '0)
        else $error("ready raised for a requester that is not valid");

endmodule

/* src/request_crossbar.sv */
module request_crossbar (
    input  logic [scratch_pkg::NUM_REQS-1:0]                   req_rw,
    input  scratch_pkg::row_t [scratch_pkg::NUM_REQS-1:0]      req_row,
    input  scratch_pkg::byteen_t [scratch_pkg::NUM_REQS-1:0]   req_byteen,
    input  scratch_pkg::word_t [scratch_pkg::NUM_REQS-1:0]     req_data,
    input  scratch_pkg::tag_t [scratch_pkg::NUM_REQS-1:0]      req_tag,
    input  scratch_pkg::req_idx_t [scratch_pkg::NUM_BANKS-1:0] bank_winner,
    output logic [scratch_pkg::NUM_BANKS-1:0]                  bank_rw,
    output scratch_pkg::row_t [scratch_pkg::NUM_BANKS-1:0]     bank_row,
    output scratch_pkg::byteen_t [scratch_pkg::NUM_BANKS-1:0]  bank_byteen,
    output scratch_pkg::word_t [scratch_pkg::NUM_BANKS-1:0]    bank_data,
    output scratch_pkg::tag_t [scratch_pkg::NUM_BANKS-1:0]     bank_tag
);

    // One payload mux per bank, steered by the arbiter's winner
    for (genvar b = 0; b < scratch_pkg::NUM_BANKS; b++) begin : g_bank_mux
        assign bank_rw[b]     = req_rw[bank_winner[b]];
        assign bank_row[b]    = req_row[bank_winner[b]];
        assign bank_byteen[b] = req_byteen[bank_winner[b]];
        assign bank_data[b]   = req_data[bank_winner[b]];
        assign bank_tag[b]    = req_tag[bank_winner[b]];
    end

endmodule

/* bank/cache_bank.sv */
module cache_bank (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  access_valid,
    input  logic                  access_rw,
    input  scratch_pkg::row_t     access_row,
    input  scratch_pkg::byteen_t  access_byteen,
    input  scratch_pkg::word_t    access_data,
    input  scratch_pkg::tag_t     access_tag,
    input  scratch_pkg::req_idx_t access_idx,
    output logic                  rsp_valid,
    output scratch_pkg::word_t    rsp_data,
    output scratch_pkg::tag_t     rsp_tag,
    output scratch_pkg::req_idx_t rsp_idx
);

    scratch_pkg::word_t mem [scratch_pkg::ROWS_PER_BANK];

    logic do_write;
    logic do_read;

    assign do_write = access_valid && access_rw;
    assign do_read  = access_valid && !access_rw;

    ////////////////////////////////////////////////////////////////////////////
    // Storage, byte-lane writes

    always_ff @(posedge clk) begin
        if (do_write) begin
            for (int b = 0; b < scratch_pkg::WORD_BYTES; b++) begin
                if (access_byteen[b]) begin
                    mem[access_row][b*8 +: 8] <= access_data[b*8 +: 8];
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read response, one cycle after accept

    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= do_read;
        end
    end

    // Payload only moves on a read
    always_ff @(posedge clk) begin
        if (do_read) begin
            rsp_data <= mem[access_row];
            rsp_tag  <= access_tag;
            rsp_idx  <= access_idx;
        end
    end

endmodule

/* src/response_crossbar.sv */
module response_crossbar (
    input  logic                                               clk,
    input  logic                                               reset,
    input  logic [scratch_pkg::NUM_BANKS-1:0]                  bank_rsp_valid,
    input  scratch_pkg::word_t [scratch_pkg::NUM_BANKS-1:0]    bank_rsp_data,
    input  scratch_pkg::tag_t [scratch_pkg::NUM_BANKS-1:0]     bank_rsp_tag,
    input  scratch_pkg::req_idx_t [scratch_pkg::NUM_BANKS-1:0] bank_rsp_idx,
    output logic [scratch_pkg::NUM_REQS-1:0]                   rsp_valid,
    output scratch_pkg::word_t [scratch_pkg::NUM_REQS-1:0]     rsp_data,
    output scratch_pkg::tag_t [scratch_pkg::NUM_REQS-1:0]      rsp_tag
);

    // hit[r][b] means bank b answers requester r this cycle
    logic [scratch_pkg::NUM_REQS-1:0][scratch_pkg::NUM_BANKS-1:0] hit;

    for (genvar r = 0; r < scratch_pkg::NUM_REQS; r++) begin : g_req
        for (genvar b = 0; b < scratch_pkg::NUM_BANKS; b++) begin : g_bank
            assign hit[r][b] = bank_rsp_valid[b]
                && (bank_rsp_idx[b] == scratch_pkg::req_idx_t'(r));
        end

        // Arbiter grants one bank per requester, so at most one reply
        assert property (@(posedge clk) disable iff (reset) $countones(hit[r]) <= 1)
            else $error("two banks answered requester %0d in one cycle", r);
    end

    always_comb begin
        rsp_valid = '0;
        rsp_data  = '0;
        rsp_tag   = '0;
        for (int r = 0; r < scratch_pkg::NUM_REQS; r++) begin
            for (int b = 0; b < scratch_pkg::NUM_BANKS; b++) begin
                if (hit[r][b]) begin
                    rsp_valid[r] = 1'b1;
                    rsp_data[r]  = bank_rsp_data[b];
                    rsp_tag[r]   = bank_rsp_tag[b];
                end
            end
        end
    end

endmodule

/* src/access_counters.sv */
module access_counters (
    input  logic                             clk,
    input  logic                             reset,
    input  logic [scratch_pkg::NUM_REQS-1:0] req_valid,
    input  logic [scratch_pkg::NUM_REQS-1:0] req_ready,
    input  logic [scratch_pkg::NUM_REQS-1:0] req_rw,
    output scratch_pkg::ctr_t                read_count,
    output scratch_pkg::ctr_t                write_count,
    output scratch_pkg::ctr_t                collision_count
);

    logic [scratch_pkg::NUM_REQS-1:0] fire;
    scratch_pkg::ctr_t                reads_now;
    scratch_pkg::ctr_t                writes_now;
    scratch_pkg::ctr_t                stalls_now;

    assign fire       = req_valid & req_ready;
    assign reads_now  = scratch_pkg::ctr_t'($countones(fire & ~req_rw));
    assign writes_now = scratch_pkg::ctr_t'($countones(fire & req_rw));
    // Every valid loser counts as one collision
    assign stalls_now = scratch_pkg::ctr_t'($countones(req_valid & ~req_ready));

    // Counters wrap
    always_ff @(posedge clk) begin
        if (reset) begin
            read_count      <= '0;
            write_count     <= '0;
            collision_count <= '0;
        end else begin
            read_count      <= read_count + reads_now;
            write_count     <= write_count + writes_now;
            collision_count <= collision_count + stalls_now;
        end
    end

endmodule

/* src/banked_scratchpad.sv */
module banked_scratchpad (
    input  logic                                                      clk,
    input  logic                                                      reset,

    // Requester side
    input  logic [scratch_pkg::NUM_REQS-1:0]                          req_valid,
    input  logic [scratch_pkg::NUM_REQS-1:0]                          req_rw,
    input  logic [scratch_pkg::NUM_REQS-1:0][scratch_pkg::ADDR_BITS-1:0] req_addr,
    input  scratch_pkg::byteen_t [scratch_pkg::NUM_REQS-1:0]          req_byteen,
    input  scratch_pkg::word_t [scratch_pkg::NUM_REQS-1:0]            req_data,
    input  scratch_pkg::tag_t [scratch_pkg::NUM_REQS-1:0]             req_tag,
    output logic [scratch_pkg::NUM_REQS-1:0]                          req_ready,

    output logic [scratch_pkg::NUM_REQS-1:0]                          rsp_valid,
    output scratch_pkg::word_t [scratch_pkg::NUM_REQS-1:0]            rsp_data,
    output scratch_pkg::tag_t [scratch_pkg::NUM_REQS-1:0]             rsp_tag,

    // Access statistics
    output scratch_pkg::ctr_t                                         read_count,
    output scratch_pkg::ctr_t                                         write_count,
    output scratch_pkg::ctr_t                                         collision_count
);

    scratch_pkg::bank_id_t [scratch_pkg::NUM_REQS-1:0]  req_bank;
    scratch_pkg::row_t [scratch_pkg::NUM_REQS-1:0]      req_row;

    logic [scratch_pkg::NUM_BANKS-1:0]                  bank_valid;
    scratch_pkg::req_idx_t [scratch_pkg::NUM_BANKS-1:0] bank_winner;
    logic [scratch_pkg::NUM_BANKS-1:0]                  bank_rw;
    scratch_pkg::row_t [scratch_pkg::NUM_BANKS-1:0]     bank_row;
    scratch_pkg::byteen_t [scratch_pkg::NUM_BANKS-1:0]  bank_byteen;
    scratch_pkg::word_t [scratch_pkg::NUM_BANKS-1:0]    bank_data;
    scratch_pkg::tag_t [scratch_pkg::NUM_BANKS-1:0]     bank_tag;

    logic [scratch_pkg::NUM_BANKS-1:0]                  bank_rsp_valid;
    scratch_pkg::word_t [scratch_pkg::NUM_BANKS-1:0]    bank_rsp_data;
    scratch_pkg::tag_t [scratch_pkg::NUM_BANKS-1:0]     bank_rsp_tag;
    scratch_pkg::req_idx_t [scratch_pkg::NUM_BANKS-1:0] bank_rsp_idx;

    ////////////////////////////////////////////////////////////////////////////
    // Address split, bank in the low bits

    for (genvar i = 0; i < scratch_pkg::NUM_REQS; i++) begin : g_split
        assign req_bank[i] = req_addr[i][0 +: scratch_pkg::BANK_SEL_BITS];
        assign req_row[i]  = req_addr[i][scratch_pkg::BANK_SEL_BITS +: scratch_pkg::ROW_BITS];
    end

    ////////////////////////////////////////////////////////////////////////////
    // Request path

    bank_arbiter u_bank_arbiter (
        .clk         (clk),
        .reset       (reset),
        .req_valid   (req_valid),
        .req_bank    (req_bank),
        .req_ready   (req_ready),
        .bank_valid  (bank_valid),
        .bank_winner (bank_winner)
    );

    request_crossbar u_request_crossbar (
        .req_rw      (req_rw),
        .req_row     (req_row),
        .req_byteen  (req_byteen),
        .req_data    (req_data),
        .req_tag     (req_tag),
        .bank_winner (bank_winner),
        .bank_rw     (bank_rw),
        .bank_row    (bank_row),
        .bank_byteen (bank_byteen),
        .bank_data   (bank_data),
        .bank_tag    (bank_tag)
    );

    for (genvar b = 0; b < scratch_pkg::NUM_BANKS; b++) begin : g_bank
        cache_bank u_cache_bank (
            .clk           (clk),
            .reset         (reset),
            .access_valid  (bank_valid[b]),
            .access_rw     (bank_rw[b]),
            .access_row    (bank_row[b]),
            .access_byteen (bank_byteen[b]),
            .access_data   (bank_data[b]),
            .access_tag    (bank_tag[b]),
            .access_idx    (bank_winner[b]),
            .rsp_valid     (bank_rsp_valid[b]),
            .rsp_data      (bank_rsp_data[b]),
            .rsp_tag       (bank_rsp_tag[b]),
            .rsp_idx       (bank_rsp_idx[b])
        );
    end

    ////////////////////////////////////////////////////////////////////////////
    // Response path and statistics

    response_crossbar u_response_crossbar (
        .clk            (clk),
        .reset          (reset),
        .bank_rsp_valid (bank_rsp_valid),
        .bank_rsp_data  (bank_rsp_data),
        .bank_rsp_tag   (bank_rsp_tag),
        .bank_rsp_idx   (bank_rsp_idx),
        .rsp_valid      (rsp_valid),
        .rsp_data       (rsp_data),
        .rsp_tag        (rsp_tag)
    );

    access_counters u_access_counters (
        .clk             (clk),
        .reset           (reset),
        .req_valid       (req_valid),
        .req_ready       (req_ready),
        .req_rw          (req_rw),
        .read_count      (read_count),
        .write_count     (write_count),
        .collision_count (collision_count)
    );

endmodule

/* dv/scratchpad_tb.sv */
module scratchpad_tb;
    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        int                                                           test;
        logic [scratch_pkg::NUM_REQS-1:0]                             valid;
        logic [scratch_pkg::NUM_REQS-1:0]                             rw;
        logic [scratch_pkg::NUM_REQS-1:0][scratch_pkg::ADDR_BITS-1:0] addr;
        scratch_pkg::byteen_t [scratch_pkg::NUM_REQS-1:0]             byteen;
        scratch_pkg::word_t [scratch_pkg::NUM_REQS-1:0]               data;
        scratch_pkg::tag_t [scratch_pkg::NUM_REQS-1:0]                tag;
    } stim_row_t;

    logic                                                         clk;
    logic                                                         reset;
    logic [scratch_pkg::NUM_REQS-1:0]                             req_valid;
    logic [scratch_pkg::NUM_REQS-1:0]                             req_rw;
    logic [scratch_pkg::NUM_REQS-1:0][scratch_pkg::ADDR_BITS-1:0] req_addr;
    scratch_pkg::byteen_t [scratch_pkg::NUM_REQS-1:0]             req_byteen;
    scratch_pkg::word_t [scratch_pkg::NUM_REQS-1:0]               req_data;
    scratch_pkg::tag_t [scratch_pkg::NUM_REQS-1:0]                req_tag;
    logic [scratch_pkg::NUM_REQS-1:0]                             req_ready;
    logic [scratch_pkg::NUM_REQS-1:0]                             rsp_valid;
    scratch_pkg::word_t [scratch_pkg::NUM_REQS-1:0]               rsp_data;
    scratch_pkg::tag_t [scratch_pkg::NUM_REQS-1:0]                rsp_tag;
    scratch_pkg::ctr_t                                            read_count;
    scratch_pkg::ctr_t                                            write_count;
    scratch_pkg::ctr_t                                            collision_count;

    // Stimulus table and reference model state
    stim_row_t          table_q[$];
    stim_row_t          staged;
    string              test_names[$];
    logic               table_ready = 1'b0;
    scratch_pkg::word_t model_mem [scratch_pkg::NUM_BANKS * scratch_pkg::ROWS_PER_BANK];
    logic [scratch_pkg::NUM_REQS-1:0]               exp_rsp_valid = '0;
    scratch_pkg::word_t [scratch_pkg::NUM_REQS-1:0] exp_rsp_data = '0;
    scratch_pkg::tag_t [scratch_pkg::NUM_REQS-1:0]  exp_rsp_tag = '0;
    scratch_pkg::ctr_t  exp_reads = '0;
    scratch_pkg::ctr_t  exp_writes = '0;
    scratch_pkg::ctr_t  exp_collisions = '0;
    int                 errors = 0;
    int                 test_errors = 0;

    banked_scratchpad u_banked_scratchpad (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Longest row stalls 4 cycles of 4 ns
    initial begin
        wait (table_ready);
        #(table_q.size() * 16 + 200);
        $display("watchdog: run did not complete in time");
        $display("Something failed");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reference model

    function automatic logic [scratch_pkg::NUM_REQS-1:0] predict_ready(
            input logic [scratch_pkg::NUM_REQS-1:0] valid,
            input logic [scratch_pkg::NUM_REQS-1:0][scratch_pkg::ADDR_BITS-1:0] addr);
        logic [scratch_pkg::NUM_REQS-1:0] ready;
        ready = valid;
        for (int i = 0; i < scratch_pkg::NUM_REQS; i++) begin
            for (int j = 0; j < i; j++) begin
                if (valid[j] && (addr[j] % scratch_pkg::NUM_BANKS
                                 == addr[i] % scratch_pkg::NUM_BANKS))
                    ready[i] = 1'b0;
            end
        end
        return ready;
    endfunction

    task automatic step_model(input logic [scratch_pkg::NUM_REQS-1:0] fired);
        int a;
        for (int r = 0; r < scratch_pkg::NUM_REQS; r++) begin
            a = req_addr[r];
            exp_rsp_valid[r] = 1'b0;
            if (req_valid[r] && !fired[r]) exp_collisions++;
            if (fired[r] && req_rw[r]) begin
                exp_writes++;
                for (int b = 0; b < scratch_pkg::WORD_BYTES; b++) begin
                    if (req_byteen[r][b]) model_mem[a][b*8 +: 8] = req_data[r][b*8 +: 8];
                end
            end else if (fired[r]) begin
                exp_reads++;
                exp_rsp_valid[r] = 1'b1;
                exp_rsp_data[r]  = model_mem[a];
                exp_rsp_tag[r]   = req_tag[r];
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Checking

    task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
        $display("MISMATCH %s: got %h, expected %h", name, got, exp);
        errors++;
        test_errors++;
    endtask

    task automatic failure(input string msg);
        $display("ERROR %s", msg);
        errors++;
        test_errors++;
    endtask

    task automatic check_outputs(input logic [scratch_pkg::NUM_REQS-1:0] ready_exp);
        for (int r = 0; r < scratch_pkg::NUM_REQS; r++) begin
            if (req_ready[r] !== ready_exp[r])
                mismatch($sformatf("req_ready[%0d]", r), req_ready[r], ready_exp[r]);
            if (exp_rsp_valid[r] && rsp_valid[r] !== 1'b1) begin
                failure($sformatf("read response missing on requester %0d", r));
            end else if (!exp_rsp_valid[r] && rsp_valid[r] !== 1'b0) begin
                failure($sformatf("unexpected response on requester %0d", r));
            end else if (exp_rsp_valid[r]) begin
                if (rsp_data[r] !== exp_rsp_data[r])
                    mismatch($sformatf("rsp_data[%0d]", r), rsp_data[r], exp_rsp_data[r]);
                if (rsp_tag[r] !== exp_rsp_tag[r])
                    mismatch($sformatf("rsp_tag[%0d]", r), rsp_tag[r], exp_rsp_tag[r]);
            end
        end
        if (read_count !== exp_reads) mismatch("read_count", read_count, exp_reads);
        if (write_count !== exp_writes) mismatch("write_count", write_count, exp_writes);
        if (collision_count !== exp_collisions)
            mismatch("collision_count", collision_count, exp_collisions);
    endtask

    task automatic finish_test(input string name);
        $display("test %-18s %0d errors", name, test_errors);
        test_errors = 0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus table

    task automatic put_req(input int i, input logic rw, input int addr,
            input scratch_pkg::byteen_t be, input scratch_pkg::word_t data,
            input scratch_pkg::tag_t tag);
        staged.valid[i]  = 1'b1;
        staged.rw[i]     = rw;
        staged.addr[i]   = addr;
        staged.byteen[i] = be;
        staged.data[i]   = data;
        staged.tag[i]    = tag;
    endtask

    task automatic push_row();
        staged.test = test_names.size() - 1;
        table_q.push_back(staged);
        staged = '0;
    endtask

    task automatic build_table();
        int a;
        staged = '0;
        // Fill every word so reads never see unwritten storage
        test_names.push_back("memory fill");
        for (int k = 0; k < scratch_pkg::ROWS_PER_BANK; k++) begin
            for (int i = 0; i < scratch_pkg::NUM_REQS; i++) begin
                a = k * scratch_pkg::NUM_BANKS + i;
                put_req(i, 1'b1, a, 4'hf, 32'h5ca0_0000 ^ (a * 32'h0001_0243), 4'h0);
            end
            push_row();
        end
        push_row();
        test_names.push_back("parallel banks");
        put_req(0, 1'b1, 9, 4'hf, 32'h0909_a0a0, 4'h0);
        put_req(1, 1'b1, 14, 4'hf, 32'h1414_b1b1, 4'h0);
        put_req(2, 1'b1, 19, 4'hf, 32'h1919_c2c2, 4'h0);
        put_req(3, 1'b1, 20, 4'hf, 32'h2020_d3d3, 4'h0);
        push_row();
        put_req(0, 1'b0, 20, 4'h0, '0, 4'h3);
        put_req(1, 1'b0, 19, 4'h0, '0, 4'h7);
        put_req(2, 1'b0, 9, 4'h0, '0, 4'ha);
        put_req(3, 1'b0, 14, 4'h0, '0, 4'hc);
        push_row();
        push_row();
        test_names.push_back("one bank collision");
        for (int i = 0; i < scratch_pkg::NUM_REQS; i++) begin
            put_req(i, 1'b0, 4 * i + 2, 4'h0, '0, i + 1);
        end
        push_row();
        push_row();
        test_names.push_back("byte merge");
        put_req(1, 1'b1, 33, 4'hf, 32'h1122_3344, 4'h0);
        push_row();
        put_req(1, 1'b1, 33, 4'b0101, 32'haabb_ccdd, 4'h0);
        push_row();
        put_req(2, 1'b1, 33, 4'b1000, 32'hee00_0000, 4'h0);
        put_req(3, 1'b1, 33, 4'b0010, 32'h0000_9900, 4'h0);
        push_row();
        put_req(0, 1'b0, 33, 4'h0, '0, 4'h5);
        push_row();
        push_row();
        test_names.push_back("counter sequence");
        put_req(0, 1'b1, 1, 4'hf, 32'hdead_0001, 4'h0);
        put_req(1, 1'b0, 1, 4'h0, '0, 4'h1);
        put_req(2, 1'b0, 5, 4'h0, '0, 4'h2);
        put_req(3, 1'b1, 2, 4'h3, 32'hbeef_0002, 4'h0);
        push_row();
        put_req(1, 1'b0, 12, 4'h0, '0, 4'h9);
        put_req(3, 1'b0, 28, 4'h0, '0, 4'he);
        push_row();
        push_row();
        test_names.push_back("random traffic");
        for (int k = 0; k < 200; k++) begin
            for (int i = 0; i < scratch_pkg::NUM_REQS; i++) begin
                if ($urandom % 2) begin
                    put_req(i, $urandom % 2, $urandom % 64, $urandom % 16,
                            $urandom, $urandom % 16);
                end
            end
            push_row();
        end
        push_row();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence

    initial begin
        stim_row_t                        row;
        logic [scratch_pkg::NUM_REQS-1:0] pending;
        logic [scratch_pkg::NUM_REQS-1:0] ready_exp;
        void'($urandom(68760));
        reset      = 1'b1;
        req_valid  = '0;
        req_rw     = '0;
        req_addr   = '0;
        req_byteen = '0;
        req_data   = '0;
        req_tag    = '0;
        build_table();
        table_ready = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        #1;
        check_outputs('0);
        finish_test("reset state");
        for (int n = 0; n < table_q.size(); n++) begin
            row = table_q[n];
            @(negedge clk);
            req_rw     = row.rw;
            req_addr   = row.addr;
            req_byteen = row.byteen;
            req_data   = row.data;
            req_tag    = row.tag;
            pending    = row.valid;
            // Hold the row until every valid requester has fired
            do begin
                req_valid = pending;
                #1;
                ready_exp = predict_ready(pending, req_addr);
                check_outputs(ready_exp);
                @(posedge clk);
                step_model(ready_exp);
                pending = pending & ~ready_exp;
                if (pending != '0) @(negedge clk);
            end while (pending != '0);
            if (n == table_q.size() - 1 || table_q[n+1].test != row.test)
                finish_test(test_names[row.test]);
        end
        $display("rows %0d, errors %0d, reads %0d, writes %0d, collisions %0d",
                 table_q.size(), errors, exp_reads, exp_writes, exp_collisions);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* flist.f */
common/scratch_pkg.sv
src/bank_arbiter.sv
src/request_crossbar.sv
bank/cache_bank.sv
src/response_crossbar.sv
src/access_counters.sv
src/banked_scratchpad.sv
dv/scratchpad_tb.sv
